//--- hw/rob_alloc.sv
`timescale 1ns/100ps

module rob_alloc #(
    parameter int rob_depth = rob_geom_pkg::default_rob_depth,
    localparam int ptr_w = $clog2(rob_depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rob_load,
    input  logic             retire_pulse,
    input  logic             mispredict,
    input  logic             flush_in_prog,
    input  logic             flush_done,
    input  logic [ptr_w-1:0] flush_tail,
    input  logic [ptr_w-1:0] head_ptr,
    output logic             alloc_we,
    output logic [ptr_w-1:0] alloc_ptr,
    output logic             rob_full
);

    // count needs one more bit than a pointer
    localparam int cnt_w = ptr_w + 1;

    logic [ptr_w-1:0] tail_ptr;
    logic [ptr_w-1:0] tail_next;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] tail_ext;
    logic [cnt_w-1:0] head_ext;

    // one slot stays free so head == tail always means empty
    // also full while a mispredict or its flush is being handled
    assign rob_full = (count == cnt_w'(rob_depth - 1)) | mispredict | flush_in_prog;

    // issue should already hold off, gate anyway
    assign alloc_we  = rob_load & ~rob_full;
    assign alloc_ptr = tail_ptr;

    // wrap for depths that are not a power of two
    assign tail_next = (tail_ptr == ptr_w'(rob_depth - 1)) ? '0 : tail_ptr + 1'b1;

    assign tail_ext = {1'b0, flush_tail};
    assign head_ext = {1'b0, head_ptr};

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush_done) begin
            // tail jumps back to where the flush walk started
            tail_ptr <= flush_tail;
            if (flush_tail >= head_ptr) begin
                count <= tail_ext - head_ext;
            end else begin
                count <= tail_ext + cnt_w'(rob_depth) - head_ext;
            end
        end else begin
            if (alloc_we) begin
                tail_ptr <= tail_next;
            end
            // alloc and retire in one cycle leave count alone
            case ({alloc_we, retire_pulse})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : rob_alloc

//--- hw/rob_entries.sv
`timescale 1ns/100ps

module rob_entries #(
    parameter int rob_depth = rob_geom_pkg::default_rob_depth,
    localparam int ptr_w = $clog2(rob_depth)
) (
    input  logic                 clk,
    input  logic                 rst,
    // allocation from issue
    input  logic                 alloc_we,
    input  logic [ptr_w-1:0]     alloc_ptr,
    input  rob_op_pkg::rob_op_t  alloc_op,
    input  rob_op_pkg::rob_tag_u alloc_tag,
    // completion from reservation stations
    input  logic [rob_depth-1:0] set_valid,
    input  logic                 update_br,
    input  logic [ptr_w-1:0]     br_entry,
    input  logic                 br_taken,
    // retire side
    input  logic [ptr_w-1:0]     head_ptr,
    input  logic [ptr_w-1:0]     flush_ptr,
    input  logic                 retire_clr,
    input  logic                 flush_clr,
    output rob_op_pkg::rob_op_t  head_op,
    output rob_op_pkg::rob_tag_u head_tag,
    output logic                 head_valid,
    output rob_op_pkg::rob_op_t  flush_op,
    output rob_op_pkg::rob_tag_u flush_tag,
    output logic [rob_depth-1:0] status_valid,
    output logic [rob_depth-1:0] allocated
);

    import rob_op_pkg::*;

    // payload per entry
    rob_op_t  op_arr  [rob_depth];
    rob_tag_u tag_arr [rob_depth];

    // control bits per entry
    logic [rob_depth-1:0] valid_arr;
    logic [rob_depth-1:0] alloc_arr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            alloc_arr <= '0;
        end else begin
            // completions may arrive in any order, several per cycle
            valid_arr <= valid_arr | set_valid;

            // fresh entry starts uncomputed
            if (alloc_we) begin
                alloc_arr[alloc_ptr] <= 1'b1;
                valid_arr[alloc_ptr] <= 1'b0;
            end

            // clears win over a same-cycle completion
            if (retire_clr) begin
                alloc_arr[head_ptr] <= 1'b0;
                valid_arr[head_ptr] <= 1'b0;
            end
            if (flush_clr) begin
                alloc_arr[flush_ptr] <= 1'b0;
                valid_arr[flush_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            op_arr[alloc_ptr]  <= alloc_op;
            tag_arr[alloc_ptr] <= alloc_tag;
        end
        // outcome only touches the branch view, prediction kept
        if (update_br) begin
            tag_arr[br_entry].br.actual_taken <= br_taken;
        end
    end

    // head view for retirement
    assign head_op    = op_arr[head_ptr];
    assign head_tag   = tag_arr[head_ptr];
    assign head_valid = valid_arr[head_ptr] & alloc_arr[head_ptr];

    // walk view for the flush
    assign flush_op  = op_arr[flush_ptr];
    assign flush_tag = tag_arr[flush_ptr];

    // status bitmaps back to the reservation stations
    assign status_valid = valid_arr;
    assign allocated    = alloc_arr;

endmodule : rob_entries

//--- hw/rob_geom_pkg.sv
package rob_geom_pkg;

    // number of reorder buffer entries unless the top level says otherwise
    parameter int default_rob_depth = 8;

    // pointer width at the default depth
    localparam int default_ptr_w = $clog2(default_rob_depth);

    // entry index at the default depth
    // modules size their own pointers from rob_depth
    typedef logic [default_ptr_w-1:0] rob_ptr_t;

    // one bit per entry for valid and allocated status
    typedef logic [default_rob_depth-1:0] rob_mask_t;

endpackage : rob_geom_pkg

//--- hw/rob_op_pkg.sv
package rob_op_pkg;

    // operation class carried by each entry
    typedef enum logic [3:0] {
        OP_ALU    = 4'd0,
        OP_BRANCH = 4'd1,
        OP_LB     = 4'd2,
        OP_LH     = 4'd3,
        OP_LW     = 4'd4,
        OP_SB     = 4'd5,
        OP_SH     = 4'd6,
        OP_SW     = 4'd7
    } rob_op_t;

    // architectural register index
    typedef logic [4:0] arch_reg_t;

    // branch view of the tag word
    typedef struct packed {
        logic [2:0] unused;
        logic       predicted_taken;
        logic       actual_taken;
    } br_bits_t;

    // one tag word, two readings
    // rd for alu, loads and store data source, br for branches
    typedef union packed {
        arch_reg_t rd;
        br_bits_t  br;
    } rob_tag_u;

    function automatic logic is_load(input rob_op_t op);
        return op inside {OP_LB, OP_LH, OP_LW};
    endfunction

    function automatic logic is_store(input rob_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic logic is_branch(input rob_op_t op);
        return op == OP_BRANCH;
    endfunction

endpackage : rob_op_pkg

//--- hw/rob_retire.sv
`timescale 1ns/100ps

module rob_retire #(
    parameter int rob_depth = rob_geom_pkg::default_rob_depth,
    localparam int ptr_w = $clog2(rob_depth)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  rob_op_pkg::rob_op_t   head_op,
    input  rob_op_pkg::rob_tag_u  head_tag,
    input  logic                  head_valid,
    input  rob_op_pkg::rob_op_t   flush_op,
    input  rob_op_pkg::rob_tag_u  flush_tag,
    input  logic [ptr_w-1:0]      tail_ptr,
    input  logic                  data_mem_resp,
    input  logic [1:0]            mem_offset,
    output logic [ptr_w-1:0]      head_ptr,
    output logic [ptr_w-1:0]      flush_ptr,
    output logic                  retire_clr,
    output logic                  retire_pulse,
    output logic                  flush_clr,
    output logic                  flush_done,
    output logic [ptr_w-1:0]      flush_tail,
    output logic                  mispredict,
    output logic                  flush_in_prog,
    output logic                  regfile_load,
    output logic                  ld_commit_sel,
    output rob_op_pkg::arch_reg_t retire_rd,
    output rob_op_pkg::rob_op_t   retire_op,
    output logic                  data_read,
    output logic                  data_write,
    output logic [3:0]            wmask,
    output logic                  ld_pc,
    output logic                  reallocate_tag,
    output rob_op_pkg::arch_reg_t flush_rd
);

    import rob_op_pkg::*;

    logic             flush_ip;
    logic             head_ready;
    logic             load_done;
    logic             store_done;
    logic             alu_done;
    logic             br_done;
    logic [ptr_w-1:0] head_next;
    logic [ptr_w-1:0] flush_next;

    assign head_next  = (head_ptr == ptr_w'(rob_depth - 1)) ? '0 : head_ptr + 1'b1;
    assign flush_next = (flush_ptr == ptr_w'(rob_depth - 1)) ? '0 : flush_ptr + 1'b1;

    // nothing retires while the flush walk runs
    assign head_ready = head_valid & ~flush_ip;

    // memory ops finish only on the response to a held request
    assign load_done  = head_ready & is_load(head_op) & data_read & data_mem_resp;
    assign store_done = head_ready & is_store(head_op) & data_write & data_mem_resp;
    assign alu_done   = head_ready & (head_op == OP_ALU);
    // branches leave in one cycle, right or wrong
    assign br_done    = head_ready & is_branch(head_op);

    // head branch whose outcome differs from its prediction
    assign mispredict = br_done
                      & (head_tag.br.predicted_taken != head_tag.br.actual_taken);
    assign ld_pc      = mispredict;

    assign retire_pulse = load_done | store_done | alu_done | br_done;
    assign retire_clr   = retire_pulse;

    // regfile write for alu and loads, loads take cache data
    assign regfile_load  = alu_done | load_done;
    assign ld_commit_sel = load_done;
    assign retire_rd     = head_tag.rd;
    assign retire_op     = head_op;

    // byte lanes from store size and address offset
    always_comb begin
        case (head_op)
            OP_SW:   wmask = 4'b1111;
            OP_SH:   wmask = 4'b0011 << mem_offset;
            OP_SB:   wmask = 4'b0001 << mem_offset;
            default: wmask = 4'b0000;
        endcase
    end

    // walk clears one younger entry per cycle until it meets the tail
    // with nothing younger the walk still takes a single cycle
    assign flush_in_prog = flush_ip;
    assign flush_clr     = flush_ip & (flush_ptr != tail_ptr);
    assign flush_done    = flush_ip & ((flush_ptr == tail_ptr) | (flush_next == tail_ptr));
    // tail comes back to the head, which already sits past the branch
    assign flush_tail    = head_ptr;

    // only register writers hold a tag worth reclaiming
    assign reallocate_tag = flush_clr & ((flush_op == OP_ALU) | is_load(flush_op));
    assign flush_rd       = flush_tag.rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr   <= '0;
            flush_ptr  <= '0;
            flush_ip   <= 1'b0;
            data_read  <= 1'b0;
            data_write <= 1'b0;
        end else begin
            if (retire_pulse) begin
                head_ptr <= head_next;
            end

            // walk starts at the entry right behind the branch
            if (mispredict) begin
                flush_ip  <= 1'b1;
                flush_ptr <= head_next;
            end else if (flush_ip) begin
                if (flush_done) begin
                    flush_ip <= 1'b0;
                end else begin
                    flush_ptr <= flush_next;
                end
            end

            // request rises a cycle after a ready mem op hits the head
            // held until the response, dropped at the following edge
            data_read  <= head_ready & is_load(head_op) & ~load_done;
            data_write <= head_ready & is_store(head_op) & ~store_done;
        end
    end

endmodule : rob_retire

//--- hw/rob_top.sv
`timescale 1ns/100ps

module rob_top #(
    parameter int rob_depth = rob_geom_pkg::default_rob_depth,
    localparam int ptr_w = $clog2(rob_depth)
) (
    input  logic                  clk,
    input  logic                  rst,
    // issue stage
    input  logic                  rob_load,
    input  rob_op_pkg::rob_op_t   instr_op,
    input  rob_op_pkg::rob_tag_u  instr_tag,
    // reservation stations
    input  logic [rob_depth-1:0]  set_valid,
    input  logic                  update_br,
    input  logic [ptr_w-1:0]      br_entry,
    input  logic                  br_taken,
    // data cache
    input  logic                  data_mem_resp,
    input  logic [1:0]            mem_offset,
    output logic                  rob_full,
    output logic [rob_depth-1:0]  status_valid,
    output logic [rob_depth-1:0]  allocated,
    // regfile commit
    output logic                  regfile_load,
    output logic                  ld_commit_sel,
    output rob_op_pkg::arch_reg_t retire_rd,
    output rob_op_pkg::rob_op_t   retire_op,
    output logic                  data_read,
    output logic                  data_write,
    output logic [3:0]            wmask,
    // branch recovery
    output logic                  ld_pc,
    output logic                  flush_in_prog,
    output logic                  reallocate_tag,
    output rob_op_pkg::arch_reg_t flush_rd,
    output logic [ptr_w-1:0]      head_ptr
);

    import rob_op_pkg::*;

    logic             alloc_we;
    logic [ptr_w-1:0] alloc_ptr;
    logic [ptr_w-1:0] flush_ptr;
    logic [ptr_w-1:0] flush_tail;
    logic             retire_clr;
    logic             retire_pulse;
    logic             flush_clr;
    logic             flush_done;
    logic             mispredict;
    logic             head_valid;
    rob_op_t          head_op;
    rob_op_t          flush_op;
    rob_tag_u         head_tag;
    rob_tag_u         flush_tag;

    rob_alloc #(.rob_depth(rob_depth)) u_alloc (
        .clk(clk),
        .rst(rst),
        .rob_load(rob_load),
        .retire_pulse(retire_pulse),
        .mispredict(mispredict),
        .flush_in_prog(flush_in_prog),
        .flush_done(flush_done),
        .flush_tail(flush_tail),
        .head_ptr(head_ptr),
        .alloc_we(alloc_we),
        .alloc_ptr(alloc_ptr),
        .rob_full(rob_full)
    );

    rob_entries #(.rob_depth(rob_depth)) u_entries (
        .clk(clk),
        .rst(rst),
        .alloc_we(alloc_we),
        .alloc_ptr(alloc_ptr),
        .alloc_op(instr_op),
        .alloc_tag(instr_tag),
        .set_valid(set_valid),
        .update_br(update_br),
        .br_entry(br_entry),
        .br_taken(br_taken),
        .head_ptr(head_ptr),
        .flush_ptr(flush_ptr),
        .retire_clr(retire_clr),
        .flush_clr(flush_clr),
        .head_op(head_op),
        .head_tag(head_tag),
        .head_valid(head_valid),
        .flush_op(flush_op),
        .flush_tag(flush_tag),
        .status_valid(status_valid),
        .allocated(allocated)
    );

    // tail pointer doubles as the end of the flush walk
    rob_retire #(.rob_depth(rob_depth)) u_retire (
        .clk(clk),
        .rst(rst),
        .head_op(head_op),
        .head_tag(head_tag),
        .head_valid(head_valid),
        .flush_op(flush_op),
        .flush_tag(flush_tag),
        .tail_ptr(alloc_ptr),
        .data_mem_resp(data_mem_resp),
        .mem_offset(mem_offset),
        .head_ptr(head_ptr),
        .flush_ptr(flush_ptr),
        .retire_clr(retire_clr),
        .retire_pulse(retire_pulse),
        .flush_clr(flush_clr),
        .flush_done(flush_done),
        .flush_tail(flush_tail),
        .mispredict(mispredict),
        .flush_in_prog(flush_in_prog),
        .regfile_load(regfile_load),
        .ld_commit_sel(ld_commit_sel),
        .retire_rd(retire_rd),
        .retire_op(retire_op),
        .data_read(data_read),
        .data_write(data_write),
        .wmask(wmask),
        .ld_pc(ld_pc),
        .reallocate_tag(reallocate_tag),
        .flush_rd(flush_rd)
    );

endmodule : rob_top

//--- run_sim.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module rob_tb -o rob_sim
out=$(./obj_dir/rob_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- test/rob_cases.dat
// columns op_rd_p_a_off: op (0 alu 1 branch 2 lb 3 lh 4 lw 5 sb 6 sh 7 sw), register,
// predicted taken, actual taken, store offset; op f ends a sequence, op e ends the file
0_01_0_0_0
0_02_0_0_0
0_03_0_0_0
f_00_0_0_0
4_05_0_0_0
7_09_0_0_0
2_06_0_0_1
5_0a_0_0_3
6_0b_0_0_2
3_07_0_0_0
f_00_0_0_0
0_08_0_0_0
5_0c_0_0_1
0_09_0_0_0
4_0a_0_0_0
6_0d_0_0_0
0_0b_0_0_0
1_00_1_1_0
f_00_0_0_0
1_00_0_1_0
0_0c_0_0_0
7_0e_0_0_0
2_0d_0_0_0
1_00_0_0_0
0_0e_0_0_0
f_00_0_0_0
0_0f_0_0_0
1_00_1_0_0
f_00_0_0_0
0_11_0_0_0
4_12_0_0_0
0_13_0_0_0
f_00_0_0_0
e_00_0_0_0

//--- test/rob_tb.sv
`timescale 1ns/100ps

module rob_tb;

    import rob_geom_pkg::*;
    import rob_op_pkg::*;

    localparam int depth = default_rob_depth;
    localparam int max_lines = 64;
    // cycles one sequence may take before it counts as stuck
    localparam int seq_limit = 400;

    logic      clk = 1'b0;
    logic      rst;
    logic      rob_load;
    rob_op_t   instr_op;
    rob_tag_u  instr_tag;
    rob_mask_t set_valid;
    logic      update_br;
    rob_ptr_t  br_entry;
    logic      br_taken;
    logic      data_mem_resp;
    logic [1:0] mem_offset;
    logic      rob_full;
    rob_mask_t status_valid;
    rob_mask_t allocated;
    logic      regfile_load;
    logic      ld_commit_sel;
    arch_reg_t retire_rd;
    rob_op_t   retire_op;
    logic      data_read;
    logic      data_write;
    logic [3:0] wmask;
    logic      ld_pc;
    logic      flush_in_prog;
    logic      reallocate_tag;
    arch_reg_t flush_rd;
    rob_ptr_t  head_ptr;

    // op_rd_p_a_off words from the case file
    logic [23:0] case_mem [max_lines];
    int          num_lines;
    int          limit_cycles = 0;
    int          idx;
    int unsigned seed = 91930;
    int          value_errors = 0;
    int          stall_errors = 0;
    int          cyc = 0;

    // current sequence with one slot per instruction in program order
    rob_op_t    seq_op   [depth];
    arch_reg_t  seq_rd   [depth];
    logic       seq_pred [depth];
    logic       seq_act  [depth];
    logic [1:0] seq_off  [depth];
    rob_ptr_t   seq_slot [depth];
    int         seq_done [depth];
    int         seq_len;
    rob_ptr_t   exp_head = '0;

    // reference model queues for the expected retire and flush order
    int retire_q [$];
    int flush_q  [$];
    int pend_q   [$];
    int flush_left;
    int ready_cyc;
    int req_wait;
    logic req_armed;
    logic stop_comp;

    rob_top #(.rob_depth(depth)) DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    // byte lanes from the size in bytes shifted up by the offset
    function automatic logic [3:0] store_mask(input rob_op_t op, input logic [1:0] off);
        int nbytes;
        if (op == OP_SW) begin
            return 4'b1111;
        end
        nbytes = (op == OP_SH) ? 2 : 1;
        return 4'(((1 << nbytes) - 1) << off);
    endfunction

    task automatic observe_cycle();
        int   f;
        logic ready;
        logic mem_wait;
        logic ld_op;
        logic st_op;
        logic done;
        logic writer;
        logic miss;
        if (flush_left > 0) begin
            check_val("flush_in_prog", 32'(flush_in_prog), 1);
            check_val("rob_full", 32'(rob_full), 1);
            check_val("regfile_load", 32'(regfile_load), 0);
            check_val("ld_pc", 32'(ld_pc), 0);
            // younger entries leave oldest first
            if (flush_q.size() > 0) begin
                f = flush_q.pop_front();
                writer = seq_op[f] inside {OP_ALU, OP_LB, OP_LH, OP_LW};
                check_val("reallocate_tag", 32'(reallocate_tag), 32'(writer));
                if (writer) begin
                    check_val("flush_rd", 32'(flush_rd), 32'(seq_rd[f]));
                end
            end else begin
                check_val("reallocate_tag", 32'(reallocate_tag), 0);
            end
            flush_left--;
            return;
        end
        check_val("flush_in_prog", 32'(flush_in_prog), 0);
        check_val("reallocate_tag", 32'(reallocate_tag), 0);
        if (retire_q.size() == 0) begin
            return;
        end
        f = retire_q[0];
        check_val("head_ptr", 32'(head_ptr), 32'(seq_slot[f]));
        // completion seen at an earlier edge
        ready = (seq_done[f] >= 0) && (cyc > seq_done[f]);
        // head status bit follows its completion
        check_val("status_valid", 32'(status_valid[seq_slot[f]]), 32'(ready));
        if (ready && ready_cyc < 0) begin
            ready_cyc = cyc;
        end
        // request rises one cycle after the head is ready
        mem_wait = ready && (cyc > ready_cyc);
        ld_op = seq_op[f] inside {OP_LB, OP_LH, OP_LW};
        st_op = seq_op[f] inside {OP_SB, OP_SH, OP_SW};
        check_val("data_read", 32'(data_read), 32'(ld_op && mem_wait));
        check_val("data_write", 32'(data_write), 32'(st_op && mem_wait));
        if (st_op && mem_wait) begin
            check_val("wmask", 32'(wmask), 32'(store_mask(seq_op[f], seq_off[f])));
        end
        done = (ld_op || st_op) ? data_mem_resp : ready;
        writer = done && !st_op && (seq_op[f] != OP_BRANCH);
        miss = done && (seq_op[f] == OP_BRANCH) && (seq_pred[f] != seq_act[f]);
        check_val("regfile_load", 32'(regfile_load), 32'(writer));
        check_val("ld_commit_sel", 32'(ld_commit_sel), 32'(done && ld_op));
        check_val("ld_pc", 32'(ld_pc), 32'(miss));
        if (writer) begin
            check_val("retire_rd", 32'(retire_rd), 32'(seq_rd[f]));
        end
        if (done) begin
            check_val("retire_op", 32'(retire_op), 32'(seq_op[f]));
            void'(retire_q.pop_front());
            exp_head = seq_slot[f] + 1'b1;
            ready_cyc = -1;
            // everything younger gets walked out in at least one cycle
            if (miss) begin
                flush_q = retire_q;
                retire_q = {};
                flush_left = (flush_q.size() > 0) ? flush_q.size() : 1;
                stop_comp = 1'b1;
            end
        end
        // answer a fresh cache request after 0 to 4 cycles
        if ((data_read || data_write) && !data_mem_resp && !req_armed) begin
            req_armed = 1'b1;
            req_wait = lcg_next() % 5;
        end
    endtask

    task automatic run_sequence();
        rob_mask_t exp_mask;
        int        start;
        int        k;
        int        p;
        exp_mask = '0;
        for (int i = 0; i < seq_len; i++) begin
            @(negedge clk);
            rob_load = 1'b1;
            instr_op = seq_op[i];
            // branch tag carries the prediction while the outcome is unknown
            if (seq_op[i] == OP_BRANCH) begin
                instr_tag.br = '{unused: 3'b000, predicted_taken: seq_pred[i],
                                 actual_taken: 1'b0};
            end else begin
                instr_tag.rd = seq_rd[i];
            end
            seq_slot[i] = exp_head + rob_ptr_t'(i);
            exp_mask[seq_slot[i]] = 1'b1;
            #10;
            check_val("rob_full", 32'(rob_full), 0);
        end
        @(negedge clk);
        rob_load = 1'b0;
        #10;
        check_val("allocated", 32'(allocated), 32'(exp_mask));
        check_val("status_valid", 32'(status_valid), 0);
        check_val("rob_full", 32'(rob_full), 32'(seq_len == depth - 1));
        retire_q = {};
        pend_q = {};
        for (int i = 0; i < seq_len; i++) begin
            retire_q.push_back(i);
            pend_q.push_back(i);
            seq_done[i] = -1;
        end
        flush_left = 0;
        ready_cyc = -1;
        req_armed = 1'b0;
        stop_comp = 1'b0;
        start = cyc;
        while ((retire_q.size() > 0 || flush_left > 0) && (cyc - start < seq_limit)) begin
            @(negedge clk);
            set_valid = '0;
            update_br = 1'b0;
            data_mem_resp = 1'b0;
            // one random pending entry completes in most cycles
            if (!stop_comp && pend_q.size() > 0 && (lcg_next() % 4 != 0)) begin
                k = lcg_next() % pend_q.size();
                p = pend_q[k];
                pend_q.delete(k);
                set_valid[seq_slot[p]] = 1'b1;
                seq_done[p] = cyc;
                if (seq_op[p] == OP_BRANCH) begin
                    update_br = 1'b1;
                    br_entry = seq_slot[p];
                    br_taken = seq_act[p];
                end
            end
            if (req_armed) begin
                if (req_wait == 0) begin
                    data_mem_resp = 1'b1;
                    req_armed = 1'b0;
                end else begin
                    req_wait--;
                end
            end
            if (retire_q.size() > 0) begin
                mem_offset = seq_off[retire_q[0]];
            end
            #10;
            observe_cycle();
        end
        if (retire_q.size() > 0 || flush_left > 0) begin
            stall_errors++;
            $display("gave up waiting: %0d entries never retired, %0d flush cycles missing",
                     retire_q.size(), flush_left);
        end
    endtask

    initial begin
        rst = 1'b1;
        rob_load = 1'b0;
        instr_op = OP_ALU;
        instr_tag = '0;
        set_valid = '0;
        update_br = 1'b0;
        br_entry = '0;
        br_taken = 1'b0;
        data_mem_resp = 1'b0;
        mem_offset = 2'b00;
        $readmemh("test/rob_cases.dat", case_mem);
        // marker lines do not count toward the time budget
        num_lines = 0;
        idx = 0;
        while (idx < max_lines && case_mem[idx][23:20] != 4'he) begin
            if (case_mem[idx][23:20] != 4'hf) begin
                num_lines++;
            end
            idx++;
        end
        limit_cycles = num_lines * 200 + 10;
        if (num_lines == 0) begin
            stall_errors++;
            $display("case file test/rob_cases.dat holds no instructions");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #10;
        check_val("regfile_load", 32'(regfile_load), 0);
        check_val("ld_commit_sel", 32'(ld_commit_sel), 0);
        check_val("data_read", 32'(data_read), 0);
        check_val("data_write", 32'(data_write), 0);
        check_val("ld_pc", 32'(ld_pc), 0);
        check_val("flush_in_prog", 32'(flush_in_prog), 0);
        check_val("reallocate_tag", 32'(reallocate_tag), 0);
        check_val("rob_full", 32'(rob_full), 0);
        check_val("status_valid", 32'(status_valid), 0);
        check_val("allocated", 32'(allocated), 0);
        check_val("head_ptr", 32'(head_ptr), 0);
        idx = 0;
        while (idx < max_lines && case_mem[idx][23:20] != 4'he) begin
            seq_len = 0;
            while (idx < max_lines && seq_len < depth - 1 && case_mem[idx][23:20] != 4'hf) begin
                seq_op[seq_len] = rob_op_t'(case_mem[idx][23:20]);
                seq_rd[seq_len] = case_mem[idx][16:12];
                seq_pred[seq_len] = case_mem[idx][8];
                seq_act[seq_len] = case_mem[idx][4];
                seq_off[seq_len] = case_mem[idx][1:0];
                seq_len++;
                idx++;
            end
            idx++;
            run_sequence();
        end
        $display("errors: %0d value mismatches, %0d stalled waits", value_errors, stall_errors);
        if (value_errors == 0 && stall_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // run length bound from the number of case lines
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired: the run did not finish within %0d cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : rob_tb

//--- vlog.f
hw/rob_geom_pkg.sv
hw/rob_op_pkg.sv
hw/rob_alloc.sv
hw/rob_entries.sv
hw/rob_retire.sv
hw/rob_top.sv
test/rob_tb.sv
